// File: rtl/core_cfg_pkg.sv
// Sizes and index types of the core
// Physical tags 0 to num_arch-1 hold the architectural state after reset
// The free list starts with the remaining tags

package core_cfg_pkg;

  localparam int data_width = 16;
  localparam int num_arch   = 8;
  localparam int num_phys   = 16;
  localparam int num_rob    = 8;
  localparam int num_free   = num_phys - num_arch;   // Tags not mapped at reset
  localparam int num_rs     = 4;

  localparam int arch_bits = $clog2(num_arch);
  localparam int phys_bits = $clog2(num_phys);
  localparam int rob_bits  = $clog2(num_rob);
  localparam int rs_bits   = $clog2(num_rs);
  localparam int free_bits = $clog2(num_free);

  // First tag handed out by the free list after reset
  localparam int first_free_tag = num_arch;

  typedef logic [data_width-1:0] data_t;
  typedef logic [arch_bits-1:0]  arch_reg_t;
  typedef logic [phys_bits-1:0]  phys_reg_t;
  typedef logic [rob_bits-1:0]   rob_idx_t;
  typedef logic [rs_bits-1:0]    rs_idx_t;

endpackage

// File: rtl/isa_pkg.sv
// Instruction set of the core
// Every opcode outside opcode_t is illegal and stops the core
// Immediate of load-immediate is zero-extended

package isa_pkg;

  localparam int inst_width = 16;

  // Field positions
  localparam int op_hi  = 15;
  localparam int op_lo  = 12;
  localparam int rd_hi  = 11;
  localparam int rd_lo  = 9;
  localparam int rs1_hi = 8;
  localparam int rs1_lo = 6;
  localparam int rs2_hi = 5;
  localparam int rs2_lo = 3;
  localparam int imm_hi = 8;
  localparam int imm_lo = 0;

  typedef logic [inst_width-1:0] inst_t;

  typedef enum logic [3:0] {
    op_add  = 4'h0,
    op_sub  = 4'h1,
    op_and  = 4'h2,
    op_xor  = 4'h3,
    op_li   = 4'h4,
    op_halt = 4'hf
  } opcode_t;

  // Five operations, so three bits
  typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_xor, alu_pass} alu_op_t;

  typedef enum logic [1:0] {st_running, st_halted, st_illegal} core_status_t;

endpackage

// File: rtl/decoder.sv
// Purely combinational instruction decode
// Halt and illegal opcodes never reach the functional unit

`timescale 1ns/1ns

module decoder (
  input  isa_pkg::inst_t          inst,
  output isa_pkg::alu_op_t        alu_op,
  output core_cfg_pkg::arch_reg_t rd,
  output core_cfg_pkg::arch_reg_t rs1,
  output core_cfg_pkg::arch_reg_t rs2,
  output core_cfg_pkg::data_t     imm,
  output logic                    uses_fu,
  output logic                    use_imm,
  output logic                    writes_rd,
  output logic                    is_stop,
  output logic                    stop_illegal
);
  import core_cfg_pkg::*;
  import isa_pkg::*;

  opcode_t opc;

  assign opc = opcode_t'(inst[op_hi:op_lo]);
  assign rd  = inst[rd_hi:rd_lo];
  assign rs1 = inst[rs1_hi:rs1_lo];
  assign rs2 = inst[rs2_hi:rs2_lo];
  assign imm = data_t'(inst[imm_hi:imm_lo]);  // Zero-extend

  always_comb begin
    alu_op       = alu_pass;
    uses_fu      = 1'b1;
    use_imm      = 1'b0;
    is_stop      = 1'b0;
    stop_illegal = 1'b0;
    case (opc)
      op_add:  alu_op = alu_add;
      op_sub:  alu_op = alu_sub;
      op_and:  alu_op = alu_and;
      op_xor:  alu_op = alu_xor;
      op_li:   use_imm = 1'b1;     // Pass immediate as operand B
      op_halt: begin
        uses_fu = 1'b0;
        is_stop = 1'b1;
      end
      default: begin
        uses_fu      = 1'b0;
        is_stop      = 1'b1;
        stop_illegal = 1'b1;
      end
    endcase
  end

  assign writes_rd = uses_fu;   // Every ALU operation writes rd

endmodule

// File: rtl/map_table.sv
// Speculative rename map, no rollback
// Reads see the map before the update of the same cycle

`timescale 1ns/1ns

module map_table (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    dispatch_en,
  input  logic                    writes_rd,
  input  core_cfg_pkg::arch_reg_t rs1,
  input  core_cfg_pkg::arch_reg_t rs2,
  input  core_cfg_pkg::arch_reg_t rd,
  input  core_cfg_pkg::phys_reg_t new_tag,
  output core_cfg_pkg::phys_reg_t src1_tag,
  output core_cfg_pkg::phys_reg_t src2_tag,
  output core_cfg_pkg::phys_reg_t old_tag
);
  import core_cfg_pkg::*;

  phys_reg_t map_q [num_arch];

  assign src1_tag = map_q[rs1];
  assign src2_tag = map_q[rs2];
  assign old_tag  = map_q[rd];    // Freed when this instruction retires

  always_ff @(posedge clock) begin
    if (reset) begin
      // Identity map
      for (int i = 0; i < num_arch; i++) begin
        map_q[i] <= phys_reg_t'(i);
      end
    end else if (dispatch_en && writes_rd) begin
      map_q[rd] <= new_tag;
    end
  end

endmodule

// File: rtl/free_list.sv
// Circular queue of free physical tags
// Pop at dispatch of a writer, push of the old tag at retire
// Never overflows, since only tags taken from it come back

`timescale 1ns/1ns

module free_list (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    dispatch_en,
  input  logic                    writes_rd,
  input  logic                    retire_en,
  input  core_cfg_pkg::phys_reg_t retire_old_tag,
  output core_cfg_pkg::phys_reg_t new_tag,
  output logic                    fl_ready
);
  import core_cfg_pkg::*;

  phys_reg_t            fifo_q [num_free];
  logic [free_bits-1:0] head;
  logic [free_bits-1:0] tail;
  logic [free_bits:0]   count;
  logic                 pop;

  assign pop      = dispatch_en && writes_rd;
  assign new_tag  = fifo_q[head];
  assign fl_ready = (count != '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;                               // Full, so tail meets head
      count <= (free_bits + 1)'(num_free);
      for (int i = 0; i < num_free; i++) begin
        fifo_q[i] <= phys_reg_t'(first_free_tag + i);
      end
    end else begin
      if (pop) head <= head + 1'b1;
      if (retire_en) begin
        fifo_q[tail] <= retire_old_tag;
        tail         <= tail + 1'b1;
      end
      if (pop && !retire_en) count <= count - 1'b1;
      else if (!pop && retire_en) count <= count + 1'b1;
    end
  end

endmodule

// File: rtl/rob.sv
// Reorder buffer, in-order retire of one entry per cycle
// Halt and illegal enter complete and freeze the core when they reach the head
// Only reset leaves the stopped state

`timescale 1ns/1ns

module rob (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       dispatch_en,
  input  logic                       writes_rd,
  input  core_cfg_pkg::arch_reg_t    rd,
  input  core_cfg_pkg::phys_reg_t    new_tag,
  input  core_cfg_pkg::phys_reg_t    old_tag,
  input  logic                       uses_fu,
  input  logic                       is_stop,
  input  logic                       stop_illegal,
  input  logic                       cdb_valid,
  input  core_cfg_pkg::rob_idx_t     cdb_rob_idx,
  input  core_cfg_pkg::data_t        cdb_value,
  output core_cfg_pkg::rob_idx_t     rob_tail_idx,
  output logic                       rob_ready,
  output logic                       retire_en,
  output core_cfg_pkg::phys_reg_t    retire_old_tag,
  output logic                       retire_valid,
  output core_cfg_pkg::arch_reg_t    retire_rd,
  output core_cfg_pkg::data_t        retire_value,
  output isa_pkg::core_status_t      status
);
  import core_cfg_pkg::*;
  import isa_pkg::*;

  arch_reg_t          rd_q    [num_rob];
  phys_reg_t          new_q   [num_rob];
  phys_reg_t          old_q   [num_rob];
  data_t              value_q [num_rob];
  logic [num_rob-1:0] done_q;
  logic [num_rob-1:0] stop_q;
  logic [num_rob-1:0] ill_q;
  rob_idx_t           head;
  rob_idx_t           tail;
  logic [rob_bits:0]  count;
  logic               stop_seen;   // Halt or illegal dispatched
  logic               head_ok;
  logic               retiring;

  assign rob_tail_idx = tail;
  assign rob_ready    = (count != (rob_bits + 1)'(num_rob)) && !stop_seen;

  assign head_ok  = (count != '0) && done_q[head] && (status == st_running);
  assign retiring = head_ok && !stop_q[head];

  assign retire_valid   = retiring;
  assign retire_rd      = rd_q[head];
  assign retire_value   = value_q[head];
  assign retire_old_tag = old_q[head];
  // Non-writers hold equal tags, so nothing goes back to the free list
  assign retire_en      = retiring && (new_q[head] != old_q[head]);

  //////////////////////////////////////////////////////////////////////
  // Pointers and status
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      stop_seen <= 1'b0;
      status    <= st_running;
    end else begin
      if (dispatch_en) begin
        tail <= tail + 1'b1;
        if (is_stop) stop_seen <= 1'b1;
      end
      if (retiring) head <= head + 1'b1;
      if (dispatch_en && !retiring) count <= count + 1'b1;
      else if (!dispatch_en && retiring) count <= count - 1'b1;
      if (head_ok && stop_q[head]) begin
        status <= ill_q[head] ? st_illegal : st_halted;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Entry contents
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (cdb_valid) begin
      done_q[cdb_rob_idx]  <= 1'b1;
      value_q[cdb_rob_idx] <= cdb_value;
    end
    if (dispatch_en) begin
      rd_q[tail]   <= rd;
      new_q[tail]  <= writes_rd ? new_tag : old_tag;
      old_q[tail]  <= old_tag;
      done_q[tail] <= !uses_fu;       // Stops are complete at once
      stop_q[tail] <= is_stop;
      ill_q[tail]  <= stop_illegal;
    end
  end

endmodule

// File: rtl/res_station.sv
// Four-entry reservation station for the single ALU
// Fills the lowest free entry, issues the lowest entry with both sources ready
// Issue is combinational from registered ready bits

`timescale 1ns/1ns

module res_station (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    dispatch_en,
  input  logic                    uses_fu,
  input  isa_pkg::alu_op_t        alu_op,
  input  logic                    use_imm,
  input  core_cfg_pkg::data_t     imm,
  input  core_cfg_pkg::phys_reg_t src1_tag,
  input  core_cfg_pkg::phys_reg_t src2_tag,
  input  logic                    src1_ready,
  input  logic                    src2_ready,
  input  core_cfg_pkg::phys_reg_t new_tag,
  input  core_cfg_pkg::rob_idx_t  rob_tail_idx,
  input  logic                    cdb_valid,
  input  core_cfg_pkg::phys_reg_t cdb_tag,
  output logic                    rs_ready,
  output logic                    issue_valid,
  output isa_pkg::alu_op_t        issue_op,
  output core_cfg_pkg::phys_reg_t issue_src1_tag,
  output core_cfg_pkg::phys_reg_t issue_src2_tag,
  output logic                    issue_use_imm,
  output core_cfg_pkg::data_t     issue_imm,
  output core_cfg_pkg::phys_reg_t issue_dest_tag,
  output core_cfg_pkg::rob_idx_t  issue_rob_idx
);
  import core_cfg_pkg::*;
  import isa_pkg::*;

  logic [num_rs-1:0] valid_q;
  logic [num_rs-1:0] rdy1_q;
  logic [num_rs-1:0] rdy2_q;
  alu_op_t           op_q     [num_rs];
  logic [num_rs-1:0] imm_sel_q;
  data_t             imm_q    [num_rs];
  phys_reg_t         tag1_q   [num_rs];
  phys_reg_t         tag2_q   [num_rs];
  phys_reg_t         dest_q   [num_rs];
  rob_idx_t          rob_q    [num_rs];
  logic              free_found;
  rs_idx_t           free_idx;
  rs_idx_t           issue_idx;
  logic              wr_en;
  logic              in_rdy1;
  logic              in_rdy2;

  // Lowest free and lowest ready entry
  always_comb begin
    free_found  = 1'b0;
    free_idx    = '0;
    issue_valid = 1'b0;
    issue_idx   = '0;
    for (int i = num_rs - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_found = 1'b1;
        free_idx   = rs_idx_t'(i);
      end
      if (valid_q[i] && rdy1_q[i] && rdy2_q[i]) begin
        issue_valid = 1'b1;
        issue_idx   = rs_idx_t'(i);
      end
    end
  end

  assign rs_ready = free_found;
  assign wr_en    = dispatch_en && uses_fu;

  // Immediate ops need no source, bus hits in the dispatch cycle count as ready
  assign in_rdy1 = use_imm || src1_ready || (cdb_valid && cdb_tag == src1_tag);
  assign in_rdy2 = use_imm || src2_ready || (cdb_valid && cdb_tag == src2_tag);

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      if (issue_valid) valid_q[issue_idx] <= 1'b0;
      if (wr_en) valid_q[free_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < num_rs; i++) begin
      if (cdb_valid && tag1_q[i] == cdb_tag) rdy1_q[i] <= 1'b1;   // Wakeup
      if (cdb_valid && tag2_q[i] == cdb_tag) rdy2_q[i] <= 1'b1;
    end
    if (wr_en) begin
      op_q[free_idx]      <= alu_op;
      imm_sel_q[free_idx] <= use_imm;
      imm_q[free_idx]     <= imm;
      tag1_q[free_idx]    <= src1_tag;
      tag2_q[free_idx]    <= src2_tag;
      rdy1_q[free_idx]    <= in_rdy1;
      rdy2_q[free_idx]    <= in_rdy2;
      dest_q[free_idx]    <= new_tag;
      rob_q[free_idx]     <= rob_tail_idx;
    end
  end

  assign issue_op       = op_q[issue_idx];
  assign issue_src1_tag = tag1_q[issue_idx];
  assign issue_src2_tag = tag2_q[issue_idx];
  assign issue_use_imm  = imm_sel_q[issue_idx];
  assign issue_imm      = imm_q[issue_idx];
  assign issue_dest_tag = dest_q[issue_idx];
  assign issue_rob_idx  = rob_q[issue_idx];

endmodule

// File: rtl/phys_regfile.sv
// Physical register values and ready bits
// Reset leaves every register zero and ready
// Bus write and rename clear never hit the same tag

`timescale 1ns/1ns

module phys_regfile (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    dispatch_en,
  input  logic                    writes_rd,
  input  core_cfg_pkg::phys_reg_t new_tag,
  input  core_cfg_pkg::phys_reg_t src1_tag,
  input  core_cfg_pkg::phys_reg_t src2_tag,
  input  logic                    cdb_valid,
  input  core_cfg_pkg::phys_reg_t cdb_tag,
  input  core_cfg_pkg::data_t     cdb_value,
  input  core_cfg_pkg::phys_reg_t issue_src1_tag,
  input  core_cfg_pkg::phys_reg_t issue_src2_tag,
  output logic                    src1_ready,
  output logic                    src2_ready,
  output core_cfg_pkg::data_t     op_a,
  output core_cfg_pkg::data_t     op_b
);
  import core_cfg_pkg::*;

  data_t               value_q [num_phys];
  logic [num_phys-1:0] ready_q;

  assign src1_ready = ready_q[src1_tag];   // Dispatch-time lookup
  assign src2_ready = ready_q[src2_tag];

  // Issue read with bus bypass
  assign op_a = (cdb_valid && cdb_tag == issue_src1_tag) ? cdb_value : value_q[issue_src1_tag];
  assign op_b = (cdb_valid && cdb_tag == issue_src2_tag) ? cdb_value : value_q[issue_src2_tag];

  always_ff @(posedge clock) begin
    if (reset) begin
      ready_q <= '1;
      for (int i = 0; i < num_phys; i++) begin
        value_q[i] <= '0;
      end
    end else begin
      if (cdb_valid) begin
        value_q[cdb_tag] <= cdb_value;
        ready_q[cdb_tag] <= 1'b1;
      end
      if (dispatch_en && writes_rd) ready_q[new_tag] <= 1'b0;   // Fresh rename
    end
  end

endmodule

// File: rtl/alu_fu.sv
// Two-stage ALU, the only driver of the result bus
// Result is on the bus two cycles after issue, one result per cycle at most

`timescale 1ns/1ns

module alu_fu (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    issue_valid,
  input  isa_pkg::alu_op_t        issue_op,
  input  core_cfg_pkg::data_t     op_a,
  input  core_cfg_pkg::data_t     op_b,
  input  logic                    issue_use_imm,
  input  core_cfg_pkg::data_t     issue_imm,
  input  core_cfg_pkg::phys_reg_t issue_dest_tag,
  input  core_cfg_pkg::rob_idx_t  issue_rob_idx,
  output logic                    cdb_valid,
  output core_cfg_pkg::phys_reg_t cdb_tag,
  output core_cfg_pkg::rob_idx_t  cdb_rob_idx,
  output core_cfg_pkg::data_t     cdb_value
);
  import core_cfg_pkg::*;
  import isa_pkg::*;

  logic      s1_valid;
  alu_op_t   s1_op;
  data_t     s1_a;
  data_t     s1_b;
  phys_reg_t s1_tag;
  rob_idx_t  s1_rob;
  data_t     result;

  always_comb begin
    case (s1_op)
      alu_add: result = s1_a + s1_b;
      alu_sub: result = s1_a - s1_b;
      alu_and: result = s1_a & s1_b;
      alu_xor: result = s1_a ^ s1_b;
      default: result = s1_b;          // Pass, load-immediate
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      s1_valid  <= 1'b0;
      cdb_valid <= 1'b0;
    end else begin
      s1_valid  <= issue_valid;
      cdb_valid <= s1_valid;
    end
  end

  always_ff @(posedge clock) begin
    // Stage 1
    s1_op  <= issue_op;
    s1_a   <= op_a;
    s1_b   <= issue_use_imm ? issue_imm : op_b;
    s1_tag <= issue_dest_tag;
    s1_rob <= issue_rob_idx;
    // Stage 2, bus outputs
    cdb_tag     <= s1_tag;
    cdb_rob_idx <= s1_rob;
    cdb_value   <= result;
  end

endmodule

// File: rtl/ooo_pipeline.sv
// Top of the out-of-order core
// Source holds inst until dispatch_ready and inst_valid meet at a rising edge
// dispatch_ready never depends on inst_valid

`timescale 1ns/1ns

module ooo_pipeline (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    inst_valid,
  input  isa_pkg::inst_t          inst,
  output logic                    dispatch_ready,
  output logic                    retire_valid,
  output core_cfg_pkg::arch_reg_t retire_rd,
  output core_cfg_pkg::data_t     retire_value,
  output isa_pkg::core_status_t   status
);
  import core_cfg_pkg::*;
  import isa_pkg::*;

  alu_op_t   alu_op, issue_op;
  arch_reg_t rd, rs1, rs2;
  data_t     imm, issue_imm, op_a, op_b, cdb_value;
  logic      uses_fu, use_imm, writes_rd, is_stop, stop_illegal;
  phys_reg_t src1_tag, src2_tag, old_tag, new_tag, retire_old_tag;
  phys_reg_t issue_src1_tag, issue_src2_tag, issue_dest_tag, cdb_tag;
  rob_idx_t  rob_tail_idx, issue_rob_idx, cdb_rob_idx;
  logic      rob_ready, rs_ready, fl_ready, dispatch_en;
  logic      src1_ready, src2_ready, retire_en;
  logic      issue_valid, issue_use_imm, cdb_valid;

  //////////////////////////////////////////////////////////////////////
  // Dispatch enable
  //////////////////////////////////////////////////////////////////////
  assign dispatch_ready = rob_ready && rs_ready && fl_ready;
  assign dispatch_en    = inst_valid && dispatch_ready;

  decoder decoder_0 (
    .inst(inst), .alu_op(alu_op), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm),
    .uses_fu(uses_fu), .use_imm(use_imm), .writes_rd(writes_rd),
    .is_stop(is_stop), .stop_illegal(stop_illegal)
  );

  map_table map_table_0 (
    .clock(clock), .reset(reset), .dispatch_en(dispatch_en), .writes_rd(writes_rd),
    .rs1(rs1), .rs2(rs2), .rd(rd), .new_tag(new_tag),
    .src1_tag(src1_tag), .src2_tag(src2_tag), .old_tag(old_tag)
  );

  free_list free_list_0 (
    .clock(clock), .reset(reset), .dispatch_en(dispatch_en), .writes_rd(writes_rd),
    .retire_en(retire_en), .retire_old_tag(retire_old_tag),
    .new_tag(new_tag), .fl_ready(fl_ready)
  );

  rob rob_0 (
    .clock(clock), .reset(reset), .dispatch_en(dispatch_en), .writes_rd(writes_rd),
    .rd(rd), .new_tag(new_tag), .old_tag(old_tag), .uses_fu(uses_fu),
    .is_stop(is_stop), .stop_illegal(stop_illegal),
    .cdb_valid(cdb_valid), .cdb_rob_idx(cdb_rob_idx), .cdb_value(cdb_value),
    .rob_tail_idx(rob_tail_idx), .rob_ready(rob_ready),
    .retire_en(retire_en), .retire_old_tag(retire_old_tag),
    .retire_valid(retire_valid), .retire_rd(retire_rd),
    .retire_value(retire_value), .status(status)
  );

  //////////////////////////////////////////////////////////////////////
  // Issue, execute and broadcast
  //////////////////////////////////////////////////////////////////////
  res_station res_station_0 (
    .clock(clock), .reset(reset), .dispatch_en(dispatch_en), .uses_fu(uses_fu),
    .alu_op(alu_op), .use_imm(use_imm), .imm(imm),
    .src1_tag(src1_tag), .src2_tag(src2_tag),
    .src1_ready(src1_ready), .src2_ready(src2_ready),
    .new_tag(new_tag), .rob_tail_idx(rob_tail_idx),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .rs_ready(rs_ready),
    .issue_valid(issue_valid), .issue_op(issue_op),
    .issue_src1_tag(issue_src1_tag), .issue_src2_tag(issue_src2_tag),
    .issue_use_imm(issue_use_imm), .issue_imm(issue_imm),
    .issue_dest_tag(issue_dest_tag), .issue_rob_idx(issue_rob_idx)
  );

  phys_regfile phys_regfile_0 (
    .clock(clock), .reset(reset), .dispatch_en(dispatch_en), .writes_rd(writes_rd),
    .new_tag(new_tag), .src1_tag(src1_tag), .src2_tag(src2_tag),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
    .issue_src1_tag(issue_src1_tag), .issue_src2_tag(issue_src2_tag),
    .src1_ready(src1_ready), .src2_ready(src2_ready), .op_a(op_a), .op_b(op_b)
  );

  alu_fu alu_fu_0 (
    .clock(clock), .reset(reset), .issue_valid(issue_valid), .issue_op(issue_op),
    .op_a(op_a), .op_b(op_b), .issue_use_imm(issue_use_imm), .issue_imm(issue_imm),
    .issue_dest_tag(issue_dest_tag), .issue_rob_idx(issue_rob_idx),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag),
    .cdb_rob_idx(cdb_rob_idx), .cdb_value(cdb_value)
  );

endmodule

// File: bench/tb_pipeline.sv
// Testbench for the out-of-order core
// Inputs change on the falling edge, outputs are sampled there too
// Expected results come from an in-order ISA model fed in program order
// Instructions presented after a stop are never modeled, they must not dispatch

`timescale 1ns/1ns

module tb_pipeline;
  import core_cfg_pkg::*;
  import isa_pkg::*;

  localparam int n_random      = 300;
  localparam int n_dense       = 120;
  localparam int n_halt        = 40;
  localparam int n_late        = 5;
  localparam int n_ill         = 20;
  localparam int quiet_cycles  = 50;
  localparam int settle_cycles = 20;
  localparam int total_insts   = n_random + n_dense + n_halt + 1 + n_late + n_ill + 1;
  localparam int watchdog_cycles = total_insts * 40 + 2 * 16 + 2 * quiet_cycles
                                   + 2 * settle_cycles;

  logic         clock;
  logic         reset;
  logic         inst_valid;
  inst_t        inst;
  logic         dispatch_ready;
  logic         retire_valid;
  arch_reg_t    retire_rd;
  data_t        retire_value;
  core_status_t status;

  logic [31:0]  lfsr_state = 32'hd16d98ff;
  data_t        model_regs [num_arch];
  arch_reg_t    last_rd;
  arch_reg_t    exp_rd_q [$];
  data_t        exp_val_q [$];
  int           retire_count = 0;
  int           stall_count  = 0;

  ooo_pipeline i_dut (
    .clock(clock), .reset(reset), .inst_valid(inst_valid), .inst(inst),
    .dispatch_ready(dispatch_ready), .retire_valid(retire_valid),
    .retire_rd(retire_rd), .retire_value(retire_value), .status(status)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and compare tasks
  //////////////////////////////////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("Something failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_retire(input arch_reg_t exp_rd, input data_t exp_value);
    if (retire_rd !== exp_rd || retire_value !== exp_value) begin
      $display("ERR %0t: retired r%0d = %h, expected r%0d = %h",
               $time, retire_rd, retire_value, exp_rd, exp_value);
      abort_run("retired result differs from the ISA model");
    end
  endtask

  task automatic check_status(input core_status_t exp);
    if (status !== exp) begin
      $display("ERR %0t: status %s, expected %s", $time, status.name(), exp.name());
      abort_run("core status differs from the expected one");
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      abort_run("control output has the wrong level");
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp) begin
      $display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
      abort_run("instruction count differs");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Random source and ISA model
  //////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // Galois taps 32,22,2,1
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic data_t model_result(input opcode_t op, input data_t a, input data_t b);
    case (op)
      op_add:  return a + b;
      op_sub:  return a - b;
      op_and:  return a & b;
      default: return a ^ b;
    endcase
  endfunction

  // Builds one ALU or load-immediate word and queues its expected retirement
  task automatic make_inst(output inst_t w);
    logic [2:0] sel;
    opcode_t    op;
    arch_reg_t  rd;
    arch_reg_t  rs1;
    arch_reg_t  rs2;
    logic [8:0] imm9;
    data_t      result;
    sel  = 3'(rand_bits(3));
    rd   = arch_reg_t'(rand_bits(3));
    rs1  = (rand_bits(1) == 32'd1) ? last_rd : arch_reg_t'(rand_bits(3));  // Chain bias
    rs2  = (rand_bits(1) == 32'd1) ? last_rd : arch_reg_t'(rand_bits(3));
    imm9 = 9'(rand_bits(9));
    if (sel >= 3'd5) begin
      op     = op_li;
      result = data_t'(imm9);
      w      = {op, rd, imm9};
    end else begin
      op     = opcode_t'({2'b00, sel[1:0]});
      result = model_result(op, model_regs[rs1], model_regs[rs2]);
      w      = {op, rd, rs1, rs2, 3'b000};
    end
    model_regs[rd] = result;
    last_rd        = rd;
    exp_rd_q.push_back(rd);
    exp_val_q.push_back(result);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus, all tasks start and end on a falling edge
  //////////////////////////////////////////////////////////////////////
  task automatic apply_reset();
    reset      = 1'b1;
    inst_valid = 1'b0;
    repeat (16) @(negedge clock);
    reset = 1'b0;
    for (int i = 0; i < num_arch; i++) begin
      model_regs[i] = '0;
    end
    last_rd = '0;
  endtask

  task automatic send_inst(input inst_t w);
    inst       = w;
    inst_valid = 1'b1;
    while (dispatch_ready !== 1'b1) begin
      stall_count = stall_count + 1;
      @(negedge clock);
    end
    @(negedge clock);      // Taken at the rising edge just passed
    inst_valid = 1'b0;
  endtask

  task automatic run_stream(input int n, input logic dense);
    inst_t w;
    int    gap;
    for (int i = 0; i < n; i++) begin
      make_inst(w);
      send_inst(w);
      if (!dense) begin
        gap = int'(rand_bits(2));
        repeat (gap) @(negedge clock);
      end
    end
  endtask

  // Words offered after a stop, none may be taken
  task automatic present_blocked(input int n);
    for (int i = 0; i < n; i++) begin
      inst       = inst_t'(rand_bits(16));
      inst_valid = 1'b1;
      check_flag("dispatch_ready after stop", dispatch_ready, 1'b0);
      @(negedge clock);
    end
    inst_valid = 1'b0;
  endtask

  // Stray retirements after the last expected one land in the count
  task automatic drain_queue();
    while (exp_rd_q.size() != 0) @(negedge clock);
    repeat (settle_cycles) @(negedge clock);
  endtask

  task automatic wait_for_stop();
    while (status == st_running) @(negedge clock);
    if (exp_rd_q.size() != 0) abort_run("core stopped before older instructions retired");
  endtask

  // Retire monitor, every pulse counts
  always @(negedge clock) begin
    arch_reg_t exp_rd;
    data_t     exp_value;
    if (!reset && retire_valid) begin
      retire_count = retire_count + 1;
      if (exp_rd_q.size() != 0) begin
        exp_rd    = exp_rd_q.pop_front();
        exp_value = exp_val_q.pop_front();
        check_retire(exp_rd, exp_value);
      end
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    abort_run("timeout, the core stopped making progress");
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    int         start_count;
    logic [3:0] bad_op;
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    apply_reset();
    check_flag("retire_valid after reset", retire_valid, 1'b0);
    check_status(st_running);
    check_flag("dispatch_ready after reset", dispatch_ready, 1'b1);

    start_count = retire_count;
    run_stream(n_random, 1'b0);
    drain_queue();
    check_count("random stream retirements", retire_count - start_count, n_random);

    // Dense stream, no gaps
    stall_count = 0;
    start_count = retire_count;
    run_stream(n_dense, 1'b1);
    drain_queue();
    if (stall_count == 0) abort_run("dispatch_ready never dropped during the dense stream");
    check_count("dense stream retirements", retire_count - start_count, n_dense);

    start_count = retire_count;
    run_stream(n_halt, 1'b0);
    send_inst({op_halt, 12'h000});
    present_blocked(n_late);
    wait_for_stop();
    check_status(st_halted);
    repeat (quiet_cycles) @(negedge clock);   // Late retirements show in the count
    check_status(st_halted);
    check_count("halt run retirements", retire_count - start_count, n_halt);

    apply_reset();
    check_status(st_running);
    start_count = retire_count;
    run_stream(n_ill, 1'b0);
    bad_op = 4'h5 + 4'(rand_bits(3));         // Unused opcodes 5 to 12
    send_inst({bad_op, 12'h000});
    wait_for_stop();
    check_status(st_illegal);
    repeat (quiet_cycles) @(negedge clock);
    check_status(st_illegal);
    check_count("illegal run retirements", retire_count - start_count, n_ill);

    $display("Everything OK");
    $finish;
  end

endmodule

// File: vlog.f
rtl/core_cfg_pkg.sv
rtl/isa_pkg.sv
rtl/decoder.sv
rtl/map_table.sv
rtl/free_list.sv
rtl/rob.sv
rtl/res_station.sv
rtl/phys_regfile.sv
rtl/alu_fu.sv
rtl/ooo_pipeline.sv
bench/tb_pipeline.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_pipeline
FILELIST   := vlog.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --timescale 1ns/1ns
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ns

.PHONY: all run lint clean

all: run

run:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
